// ==== logic/mem_pkg.sv ====
package mem_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    // memory operation carried down from execute
    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr,
        op_sb,
        op_sh,
        op_sw
    } mem_op_t;

    // 120 bits held by the mem and wb pipeline registers
    typedef struct packed {
        logic [word_w-1:0]     pc;
        mem_op_t               mem_op;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [word_w-1:0]     alu_result;  // final result once past mem
        logic [word_w-1:0]     rt_value;
        logic                  inst_mfc0;
        logic                  inst_mtc0;
        logic                  inst_eret;
        logic [4:0]            cp0_reg;
        logic                  ex;
        logic [4:0]            excode;
    } ms_fields_t;

endpackage

// ==== logic/cp0_pkg.sv ====
package cp0_pkg;

    // cp0 register numbers
    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;

    // exception codes for cause.excode
    localparam logic [4:0] exc_adel = 5'd4;  // load or fetch address error
    localparam logic [4:0] exc_ades = 5'd5;  // store address error

    localparam int status_exl_bit = 1;

    // fixed exception vector in the boot region
    localparam logic [31:0] exc_entry = 32'hbfc0_0380;

endpackage

// ==== logic/stage_if.sv ====
`timescale 1ns/1ps

// handshake and payload between the mem and wb stages
interface stage_if
    import mem_pkg::*;
();

    logic       valid;    // stage holds an operation
    logic       allowin;  // next stage can take it
    ms_fields_t fields;

    modport source (
        output valid,
        output fields,
        input  allowin
    );

    modport sink (
        input  valid,
        input  fields,
        output allowin
    );

endinterface

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_words = 256
) (
    input  logic        clk,
    input  logic        en,
    input  logic [3:0]  we,
    input  logic [31:0] addr,   // byte address with the low two bits ignored
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int idx_w = $clog2(ram_words);

    logic [31:0]      mem [ram_words];
    logic [idx_w-1:0] idx;

    assign idx = addr[idx_w+1:2];  // word index

    // read returns the old word when written in the same cycle
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import mem_pkg::*;
    import cp0_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  ex_valid,
    input  mem_op_t               ex_mem_op,
    input  logic [word_w-1:0]     ex_alu_result,
    input  logic [word_w-1:0]     ex_rt_value,
    input  logic [reg_addr_w-1:0] ex_dest,
    input  logic                  ex_gr_we,
    input  logic                  ex_inst_mfc0,
    input  logic                  ex_inst_mtc0,
    input  logic                  ex_inst_eret,
    input  logic [4:0]            ex_cp0_reg,
    input  logic [word_w-1:0]     ex_pc,
    input  logic                  ex_ex,
    input  logic [4:0]            ex_excode,
    output logic                  ms_allowin,
    output logic                  ram_en,
    output logic [3:0]            ram_we,
    output logic [word_w-1:0]     ram_addr,
    output logic [word_w-1:0]     ram_wdata,
    input  logic [31:0]           ram_rdata,
    stage_if.source               out,
    output logic [reg_addr_w-1:0] fwd_ms_dest,
    output logic [word_w-1:0]     fwd_ms_result,
    output logic                  ms_inst_mfc0_fwd,
    output logic                  ms_ex_fwd
);

    logic        ms_valid;
    ms_fields_t  ms_r;
    ms_fields_t  fields_in;
    logic        accept;
    logic [1:0]  ex_off;
    logic        mis_load;
    logic        mis_store;
    logic [3:0]  st_be;
    logic [1:0]  off;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] load_data;
    logic [31:0] final_result;
    logic        is_load;

    assign ms_allowin = !ms_valid || out.allowin;
    assign accept     = ex_valid && ms_allowin && !flush;

    // alignment checks on the incoming address
    assign ex_off    = ex_alu_result[1:0];
    assign mis_load  = ((ex_mem_op == op_lh || ex_mem_op == op_lhu) && ex_off[0])
                    || (ex_mem_op == op_lw && ex_off != 2'b00);
    assign mis_store = (ex_mem_op == op_sh && ex_off[0])
                    || (ex_mem_op == op_sw && ex_off != 2'b00);

    always_comb begin
        fields_in = '{pc: ex_pc, mem_op: ex_mem_op, gr_we: ex_gr_we, dest: ex_dest,
                      alu_result: ex_alu_result, rt_value: ex_rt_value,
                      inst_mfc0: ex_inst_mfc0, inst_mtc0: ex_inst_mtc0,
                      inst_eret: ex_inst_eret, cp0_reg: ex_cp0_reg,
                      ex: ex_ex, excode: ex_excode};
        if (!ex_ex && mis_load) begin
            fields_in.ex     = 1'b1;
            fields_in.excode = exc_adel;  // alu_result already is badvaddr
        end else if (!ex_ex && mis_store) begin
            fields_in.ex     = 1'b1;
            fields_in.excode = exc_ades;
        end
    end

    // store lanes
    always_comb begin
        case (ex_mem_op)
            op_sb: begin
                st_be     = 4'b0001 << ex_off;
                ram_wdata = {4{ex_rt_value[7:0]}};
            end
            op_sh: begin
                st_be     = ex_off[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{ex_rt_value[15:0]}};
            end
            op_sw: begin
                st_be     = 4'b1111;
                ram_wdata = ex_rt_value;
            end
            default: begin
                st_be     = 4'b0000;
                ram_wdata = ex_rt_value;
            end
        endcase
    end

    assign ram_en   = accept;                        // read only on acceptance
    assign ram_addr = {ex_alu_result[31:2], 2'b00};
    assign ram_we   = (accept && !ex_ex && !mis_store) ? st_be : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ms_r <= '0;
        end else if (accept) begin
            ms_r <= fields_in;
        end
    end

    // load alignment and extension
    assign off      = ms_r.alu_result[1:0];
    assign byte_sel = ram_rdata[{off, 3'b000} +: 8];
    assign half_sel = off[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    assign is_load  = ms_r.mem_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr};

    always_comb begin
        case (ms_r.mem_op)
            op_lb:  load_data = {{24{byte_sel[7]}}, byte_sel};
            op_lbu: load_data = {24'd0, byte_sel};
            op_lh:  load_data = {{16{half_sel[15]}}, half_sel};
            op_lhu: load_data = {16'd0, half_sel};
            op_lwl: begin
                case (off)
                    2'd0:    load_data = {ram_rdata[7:0], ms_r.rt_value[23:0]};
                    2'd1:    load_data = {ram_rdata[15:0], ms_r.rt_value[15:0]};
                    2'd2:    load_data = {ram_rdata[23:0], ms_r.rt_value[7:0]};
                    default: load_data = ram_rdata;
                endcase
            end
            op_lwr: begin
                case (off)
                    2'd0:    load_data = ram_rdata;
                    2'd1:    load_data = {ms_r.rt_value[31:24], ram_rdata[31:8]};
                    2'd2:    load_data = {ms_r.rt_value[31:16], ram_rdata[31:16]};
                    default: load_data = {ms_r.rt_value[31:8], ram_rdata[31:24]};
                endcase
            end
            default: load_data = ram_rdata;  // lw
        endcase
    end

    // faulting loads keep the address for badvaddr
    assign final_result = (is_load && !ms_r.ex) ? load_data : ms_r.alu_result;

    always_comb begin
        out.fields            = ms_r;
        out.fields.alu_result = final_result;
    end
    assign out.valid = ms_valid;

    assign fwd_ms_dest      = (ms_valid && ms_r.gr_we) ? ms_r.dest : '0;
    assign fwd_ms_result    = final_result;
    assign ms_inst_mfc0_fwd = ms_valid && ms_r.inst_mfc0;
    assign ms_ex_fwd        = ms_valid && ms_r.ex;

    // the word read on an accepting edge belongs to the op held in the next cycle
    a_read_matches_op: assert property (
        @(posedge clk) disable iff (reset)
        ram_en |=> ms_valid && (ms_r.alu_result[31:2] == $past(ram_addr[31:2]))
    );

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage
    import mem_pkg::*;
    import cp0_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    stage_if.sink                 in,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [word_w-1:0]     rf_wdata,
    output logic                  cp0_we,
    output logic [4:0]            cp0_addr,
    output logic [word_w-1:0]     cp0_wdata,
    input  logic [word_w-1:0]     cp0_rdata,
    output logic                  exc_commit,
    output logic [4:0]            exc_code,
    output logic [word_w-1:0]     exc_pc,
    output logic [word_w-1:0]     exc_badvaddr,
    output logic                  eret_commit,
    output logic                  flush,
    output logic [31:0]           flush_target,
    input  logic [31:0]           epc,
    output logic [31:0]           ws_pc
);

    logic       ws_valid;
    logic       ws_ready_go;
    ms_fields_t ws_r;

    assign ws_ready_go = 1'b1;  // retires every cycle
    assign in.allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ws_valid <= 1'b0;
            ws_r     <= '0;
        end else if (in.allowin) begin
            ws_valid <= in.valid;
            ws_r     <= in.fields;
        end
    end

    assign exc_commit   = ws_valid && ws_r.ex;
    assign eret_commit  = ws_valid && ws_r.inst_eret && !ws_r.ex;
    assign exc_code     = ws_r.excode;
    assign exc_pc       = ws_r.pc;
    assign exc_badvaddr = ws_r.alu_result;  // address of the faulting access

    assign flush        = exc_commit || eret_commit;
    assign flush_target = exc_commit ? exc_entry : epc;

    assign cp0_we    = ws_valid && ws_r.inst_mtc0 && !ws_r.ex;
    assign cp0_addr  = ws_r.cp0_reg;
    assign cp0_wdata = ws_r.rt_value;

    assign rf_we    = ws_valid && ws_r.gr_we && !ws_r.ex;
    assign rf_waddr = ws_r.dest;
    assign rf_wdata = ws_r.inst_mfc0 ? cp0_rdata : ws_r.alu_result;
    assign ws_pc    = ws_r.pc;

    // the op behind a committed exception or eret never retires
    a_no_retire_after_flush: assert property (
        @(posedge clk) disable iff (reset) flush |=> !rf_we && !cp0_we
    );

endmodule

// ==== logic/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs
    import cp0_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [4:0]  addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    input  logic        exc_commit,
    input  logic [4:0]  exc_code,
    input  logic [31:0] exc_pc,
    input  logic [31:0] exc_badvaddr,
    input  logic        eret_commit,
    output logic [31:0] epc
);

    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] badvaddr;

    // bev fixed, im[15:8], exl and ie writable in status
    always_ff @(posedge clk) begin
        if (reset) begin
            status <= 32'h0040_0000;
        end else if (exc_commit) begin
            status[status_exl_bit] <= 1'b1;
        end else if (eret_commit) begin
            status[status_exl_bit] <= 1'b0;
        end else if (we && addr == cp0_status) begin
            status[15:8] <= wdata[15:8];
            status[1:0]  <= wdata[1:0];
        end
    end

    // excode comes from hardware, mtc0 reaches only the soft interrupt bits
    always_ff @(posedge clk) begin
        if (reset) begin
            cause <= '0;
        end else if (exc_commit) begin
            cause[6:2] <= exc_code;
        end else if (we && addr == cp0_cause) begin
            cause[9:8] <= wdata[9:8];
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit) begin
            epc <= exc_pc;
        end else if (we && addr == cp0_epc) begin
            epc <= wdata;
        end
        if (exc_commit && (exc_code == exc_adel || exc_code == exc_ades)) begin
            badvaddr <= exc_badvaddr;
        end
    end

    always_comb begin
        case (addr)
            cp0_status:   rdata = status;
            cp0_cause:    rdata = cause;
            cp0_epc:      rdata = epc;
            cp0_badvaddr: rdata = badvaddr;
            default:      rdata = '0;
        endcase
    end

    // wb must never commit both in one cycle
    a_one_commit: assert property (
        @(posedge clk) disable iff (reset) !(exc_commit && eret_commit)
    );

endmodule

// ==== logic/mem_wb_top.sv ====
`timescale 1ns/1ps

module mem_wb_top
    import mem_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ex_valid,
    input  mem_op_t               ex_mem_op,
    input  logic [word_w-1:0]     ex_alu_result,
    input  logic [word_w-1:0]     ex_rt_value,
    input  logic [reg_addr_w-1:0] ex_dest,
    input  logic                  ex_gr_we,
    input  logic                  ex_inst_mfc0,
    input  logic                  ex_inst_mtc0,
    input  logic                  ex_inst_eret,
    input  logic [4:0]            ex_cp0_reg,
    input  logic [word_w-1:0]     ex_pc,
    input  logic                  ex_ex,
    input  logic [4:0]            ex_excode,
    output logic                  ms_allowin,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [word_w-1:0]     rf_wdata,
    output logic [reg_addr_w-1:0] fwd_ms_dest,
    output logic [word_w-1:0]     fwd_ms_result,
    output logic                  ms_inst_mfc0_fwd,
    output logic                  ms_ex_fwd,
    output logic                  flush,
    output logic [31:0]           flush_target
);

    logic              ram_en;
    logic [3:0]        ram_we;
    logic [word_w-1:0] ram_addr;
    logic [word_w-1:0] ram_wdata;
    logic [31:0]       ram_rdata;
    logic              cp0_we;
    logic [4:0]        cp0_addr;
    logic [31:0]       cp0_wdata;
    logic [31:0]       cp0_rdata;
    logic              exc_commit;
    logic [4:0]        exc_code;
    logic [31:0]       exc_pc;
    logic [31:0]       exc_badvaddr;
    logic              eret_commit;
    logic [31:0]       epc;

    stage_if ms_ws ();

    mem_stage i_mem_stage (
        .clk, .reset, .flush,
        .ex_valid, .ex_mem_op, .ex_alu_result, .ex_rt_value, .ex_dest, .ex_gr_we,
        .ex_inst_mfc0, .ex_inst_mtc0, .ex_inst_eret, .ex_cp0_reg, .ex_pc,
        .ex_ex, .ex_excode,
        .ms_allowin,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata,
        .out              (ms_ws.source),
        .fwd_ms_dest, .fwd_ms_result, .ms_inst_mfc0_fwd, .ms_ex_fwd
    );

    data_ram #(
        .ram_words (ram_words)
    ) i_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    wb_stage i_wb_stage (
        .clk, .reset,
        .in           (ms_ws.sink),
        .rf_we, .rf_waddr, .rf_wdata,
        .cp0_we, .cp0_addr, .cp0_wdata, .cp0_rdata,
        .exc_commit, .exc_code, .exc_pc, .exc_badvaddr, .eret_commit,
        .flush, .flush_target, .epc,
        .ws_pc        ()  // pc trace only
    );

    cp0_regs i_cp0_regs (
        .clk, .reset,
        .we           (cp0_we),
        .addr         (cp0_addr),
        .wdata        (cp0_wdata),
        .rdata        (cp0_rdata),
        .exc_commit, .exc_code, .exc_pc, .exc_badvaddr, .eret_commit,
        .epc
    );

endmodule

// ==== verif/tb_mem_wb.sv ====
`timescale 1ns/1ps

module tb_mem_wb
    import mem_pkg::*;
();

    localparam int accept_limit = 20;  // cycles to wait for ms_allowin
    localparam int result_limit = 20;  // cycles to wait for rf_we or flush

    logic        clk;
    logic        reset;
    logic        ex_valid;
    mem_op_t     ex_mem_op;
    logic [31:0] ex_alu_result;
    logic [31:0] ex_rt_value;
    logic [4:0]  ex_dest;
    logic        ex_gr_we;
    logic        ex_inst_mfc0;
    logic        ex_inst_mtc0;
    logic        ex_inst_eret;
    logic [4:0]  ex_cp0_reg;
    logic [31:0] ex_pc;
    logic        ex_ex;
    logic [4:0]  ex_excode;
    logic        ms_allowin;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [4:0]  fwd_ms_dest;
    logic [31:0] fwd_ms_result;
    logic        ms_inst_mfc0_fwd;
    logic        ms_ex_fwd;
    logic        flush;
    logic [31:0] flush_target;

    // one line of the tests file
    string       line;
    string       name;
    string       op_name;
    logic [31:0] addr;
    logic [31:0] rt;
    logic [31:0] expect_val;
    int          dest;
    int          gr_we;
    int          mfc0;
    int          mtc0;
    int          eret;
    int          cp0_sel;
    int          kind;  // 0 no writeback, 1 reg write, 2 flush, 3 dropped in flush

    int fd;
    int n_fields;
    int cycles;
    int test_idx;
    int value_errors;
    int timing_errors;
    int other_errors;
    int timeouts;

    mem_wb_top #(
        .ram_words (256)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic mem_op_t op_from_name(input string s);
        case (s)
            "lb":    return op_lb;
            "lbu":   return op_lbu;
            "lh":    return op_lh;
            "lhu":   return op_lhu;
            "lw":    return op_lw;
            "lwl":   return op_lwl;
            "lwr":   return op_lwr;
            "sb":    return op_sb;
            "sh":    return op_sh;
            "sw":    return op_sw;
            default: return op_none;
        endcase
    endfunction

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %0s %0s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic drive_op();
        ex_mem_op     = op_from_name(op_name);
        ex_alu_result = addr;
        ex_rt_value   = rt;
        ex_dest       = dest[4:0];
        ex_gr_we      = (gr_we != 0);
        ex_inst_mfc0  = (mfc0 != 0);
        ex_inst_mtc0  = (mtc0 != 0);
        ex_inst_eret  = (eret != 0);
        ex_cp0_reg    = cp0_sel[4:0];
        ex_pc         = 32'hbfc0_1000 + 4 * test_idx;
        ex_valid      = 1'b1;
    endtask

    // returns on the falling edge after the accepting edge
    task automatic wait_accept(output bit ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while (ok && (!ms_allowin || flush)) begin
            if (n == accept_limit) begin
                $display("%0s: timed out waiting for ms_allowin", name);
                timeouts++;
                ok = 1'b0;
            end else begin
                @(negedge clk);
                n++;
            end
        end
        if (ok) begin
            @(negedge clk);
            ex_valid = 1'b0;
        end
    endtask

    // hazard outputs while the op sits in the mem stage
    task automatic check_forwarding();
        logic [31:0] exp_dest;
        exp_dest = (gr_we != 0) ? dest : 0;
        compare_word("fwd_ms_dest", exp_dest, 32'(fwd_ms_dest));
        compare_word("ms_inst_mfc0_fwd", (mfc0 != 0) ? 32'd1 : 32'd0, 32'(ms_inst_mfc0_fwd));
        compare_word("ms_ex_fwd", (kind == 2 && eret == 0) ? 32'd1 : 32'd0, 32'(ms_ex_fwd));
        if (kind == 1 && mfc0 == 0) begin
            compare_word("fwd_ms_result", expect_val, fwd_ms_result);
        end
    endtask

    task automatic wait_result(output bit ok);
        ok     = 1'b1;
        cycles = 1;  // op sits in the mem stage now
        while (ok && !rf_we && !flush) begin
            if (cycles == result_limit) begin
                $display("%0s: timed out waiting for a register write or flush", name);
                timeouts++;
                ok = 1'b0;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic run_test();
        bit ok;
        ok = 1'b1;
        test_idx++;
        if (kind == 3 && !flush) begin
            other_errors++;
            $display("%0s: flush is not high when the dropped operation is offered", name);
        end
        drive_op();
        if (kind == 3) begin
            @(negedge clk);  // offered for the flush cycle only
            ex_valid = 1'b0;
        end else begin
            wait_accept(ok);
            if (ok) begin
                check_forwarding();
            end
            if (ok && kind == 0) begin
                @(negedge clk);
                if (rf_we || flush) begin
                    other_errors++;
                    $display("%0s: unexpected register write or flush", name);
                end
            end else if (ok) begin
                wait_result(ok);
            end
            if (ok && kind == 1) begin
                if (flush) begin
                    other_errors++;
                    $display("%0s: flush seen where a register write was expected", name);
                end else begin
                    compare_word("rf_wdata", expect_val, rf_wdata);
                    compare_word("rf_waddr", dest, 32'(rf_waddr));
                    compare_word("fwd_ms_dest once empty", 32'd0, 32'(fwd_ms_dest));
                end
            end
            if (ok && kind == 2) begin
                if (!flush) begin
                    other_errors++;
                    $display("%0s: register write seen where a flush was expected", name);
                end else begin
                    compare_word("flush_target", expect_val, flush_target);
                    if (rf_we) begin
                        other_errors++;
                        $display("%0s: register written while flushing", name);
                    end
                end
            end
            if (ok && kind != 0 && cycles != 2) begin
                timing_errors++;
                $display("FAIL %0s latency: expected 2, actual %0d", name, cycles);
            end
        end
    endtask

    initial begin
        reset         = 1'b1;
        ex_valid      = 1'b0;
        ex_mem_op     = op_none;
        ex_alu_result = '0;
        ex_rt_value   = '0;
        ex_dest       = '0;
        ex_gr_we      = 1'b0;
        ex_inst_mfc0  = 1'b0;
        ex_inst_mtc0  = 1'b0;
        ex_inst_eret  = 1'b0;
        ex_cp0_reg    = '0;
        ex_pc         = '0;
        ex_ex         = 1'b0;
        ex_excode     = '0;
        test_idx      = 0;
        value_errors  = 0;
        timing_errors = 0;
        other_errors  = 0;
        timeouts      = 0;

        repeat (16) @(negedge clk);
        reset = 1'b0;
        if (!ms_allowin || rf_we || flush) begin
            other_errors++;
            $display("after reset ms_allowin is not high or rf_we or flush is not low");
        end

        fd = $fopen("verif/mem_wb_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open verif/mem_wb_tests.txt");
        end else begin
            while (timeouts == 0 && $fgets(line, fd) != 0) begin
                n_fields = $sscanf(line, "%s %s %h %h %d %d %d %d %d %d %d %h", name,
                                   op_name, addr, rt, dest, gr_we, mfc0, mtc0, eret,
                                   cp0_sel, kind, expect_val);
                if (n_fields == 12) begin  // comment and blank lines fall through
                    run_test();
                end
            end
            $fclose(fd);
        end
        if (test_idx == 0) begin
            other_errors++;
            $display("no tests were read from the tests file");
        end

        $display("tests %0d, value errors %0d, timing errors %0d, other errors %0d, timeouts %0d",
                 test_idx, value_errors, timing_errors, other_errors, timeouts);
        if (value_errors + timing_errors + other_errors + timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verif/mem_wb_tests.txt ====
# name op addr rt dest gr_we mfc0 mtc0 eret cp0 kind expect (addr, rt, expect in hex)
# kind 0 no writeback, 1 register write of expect, 2 flush to expect, 3 dropped during flush
alu_pass      none 12345678 00000000 7 1 0 0 0 0  1 12345678
sw_word       sw   00000100 8899aabb 0 0 0 0 0 0  0 00000000
lw_word       lw   00000100 00000000 1 1 0 0 0 0  1 8899aabb
sb_lane1      sb   00000101 000000cc 0 0 0 0 0 0  0 00000000
lw_after_sb   lw   00000100 00000000 2 1 0 0 0 0  1 8899ccbb
sh_upper      sh   00000102 00001234 0 0 0 0 0 0  0 00000000
lw_after_sh   lw   00000100 00000000 3 1 0 0 0 0  1 1234ccbb
sw_signed     sw   00000104 80ff7f01 0 0 0 0 0 0  0 00000000
lb_0          lb   00000104 00000000 4 1 0 0 0 0  1 00000001
lb_1          lb   00000105 00000000 4 1 0 0 0 0  1 0000007f
lb_2          lb   00000106 00000000 4 1 0 0 0 0  1 ffffffff
lb_3          lb   00000107 00000000 4 1 0 0 0 0  1 ffffff80
lbu_2         lbu  00000106 00000000 4 1 0 0 0 0  1 000000ff
lbu_3         lbu  00000107 00000000 4 1 0 0 0 0  1 00000080
lh_0          lh   00000104 00000000 4 1 0 0 0 0  1 00007f01
lh_2          lh   00000106 00000000 4 1 0 0 0 0  1 ffff80ff
lhu_0         lhu  00000104 00000000 4 1 0 0 0 0  1 00007f01
lhu_2         lhu  00000106 00000000 4 1 0 0 0 0  1 000080ff
lwl_0         lwl  00000104 11223344 9 1 0 0 0 0  1 01223344
lwl_1         lwl  00000105 11223344 9 1 0 0 0 0  1 7f013344
lwl_2         lwl  00000106 11223344 9 1 0 0 0 0  1 ff7f0144
lwl_3         lwl  00000107 11223344 9 1 0 0 0 0  1 80ff7f01
lwr_0         lwr  00000104 11223344 9 1 0 0 0 0  1 80ff7f01
lwr_1         lwr  00000105 11223344 9 1 0 0 0 0  1 1180ff7f
lwr_2         lwr  00000106 11223344 9 1 0 0 0 0  1 112280ff
lwr_3         lwr  00000107 11223344 9 1 0 0 0 0  1 11223380
sw_keep       sw   00000108 5555aaaa 0 0 0 0 0 0  0 00000000
lw_misaligned lw   0000010a 00000000 5 1 0 0 0 0  2 bfc00380
mfc0_badvaddr none 00000000 00000000 6 1 1 0 0 8  1 0000010a
mfc0_cause    none 00000000 00000000 6 1 1 0 0 13 1 00000010
mtc0_epc      none 00000000 bfc01234 0 0 0 1 0 14 0 00000000
eret_to_epc   none 00000000 00000000 0 0 0 0 1 0  2 bfc01234
sw_dropped    sw   00000108 deadbeef 0 0 0 0 0 0  3 00000000
lw_kept       lw   00000108 00000000 8 1 0 0 0 0  1 5555aaaa

// ==== sources.f ====
logic/mem_pkg.sv
logic/cp0_pkg.sv
logic/stage_if.sv
logic/data_ram.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/cp0_regs.sv
logic/mem_wb_top.sv
verif/tb_mem_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mem/wb testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_wb -f sources.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mem_wb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
